/* logic/fb_params.svh */
// Tile framebuffer sizes, data widths and command field positions
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// Tile geometry of 16 by 16 pixels
`define FB_X_BITS 4
`define FB_Y_BITS 4
`define FB_ADDR_BITS 8
`define FB_PIXELS 256

// Stored pixel formats
`define FB_SUB_PIXEL_BITS 6
`define FB_COLOR_BITS 18
`define FB_DEPTH_BITS 16

// Stream widths
`define FB_CMD_BITS 32
`define FB_STREAM_BITS 16

// Opcode field of a command word
`define FB_OP_MSB 31
`define FB_OP_LSB 28

`endif

/* logic/fb_pkg.sv */
// Shared types of the tile framebuffer for opcodes, FSM states, scissor and pixels
`include "fb_params.svh"

package fb_pkg;

    // Opcodes sit in bits 31..28 and unknown codes are ignored
    typedef enum logic [3:0] {
        OP_SET_CLEAR_COLOR   = 4'h1,
        OP_SET_CLEAR_DEPTH   = 4'h2,
        OP_SET_SCISSOR_START = 4'h3,
        OP_SET_SCISSOR_END   = 4'h4,
        OP_FRAGMENT          = 4'h5,
        OP_MEMSET            = 4'h6,
        OP_COMMIT            = 4'h7
    } cmd_op_t;

    typedef enum logic [2:0] {
        DEC_IDLE,
        DEC_FRAG_COLOR,
        DEC_FRAG_WAIT,
        DEC_MEMSET_WAIT,
        DEC_COMMIT_WAIT
    } decoder_state_t;

    typedef enum logic {
        SCAN_IDLE,
        SCAN_STREAM
    } scan_state_t;

    // End coordinates are exclusive and 0 stands for 16
    typedef struct packed {
        logic                    enable;
        logic [`FB_X_BITS-1:0]   start_x;
        logic [`FB_Y_BITS-1:0]   start_y;
        logic [`FB_X_BITS-1:0]   end_x;
        logic [`FB_Y_BITS-1:0]   end_y;
    } scissor_t;

    typedef logic [`FB_COLOR_BITS-1:0] color_t;
    typedef logic [`FB_DEPTH_BITS-1:0] depth_t;

endpackage

/* logic/fb_port_if.sv */
// Fragment access port of one tile buffer for reads and scissored writes
`timescale 1ns/100ps
`include "fb_params.svh"

interface fb_port_if #(
    parameter int DATA_BITS = 18
);

    logic                      rd_en;
    logic [`FB_ADDR_BITS-1:0]  addr;
    logic [`FB_X_BITS-1:0]     x;
    logic [`FB_Y_BITS-1:0]     y;
    // Valid one cycle after rd_en
    logic [DATA_BITS-1:0]      rdata;
    logic                      wr_en;
    logic [DATA_BITS-1:0]      wdata;

    modport user (
        output rd_en, addr, x, y, wr_en, wdata,
        input  rdata
    );

    modport owner (
        input  rd_en, addr, x, y, wr_en, wdata,
        output rdata
    );

endinterface

/* logic/cmd_decoder.sv */
// Command stream decoder holding the tile configuration and sequencing long operations
`timescale 1ns/100ps
`include "fb_params.svh"

module cmd_decoder (
    input  logic                     aclk,
    input  logic                     reset,

    input  logic                     cmd_tvalid,
    output logic                     cmd_tready,
    input  logic [`FB_CMD_BITS-1:0]  cmd_tdata,

    output fb_pkg::scissor_t         scissor,
    output fb_pkg::color_t           clear_color,
    output fb_pkg::depth_t           clear_depth,

    output logic                     memset_start,
    input  logic                     memset_busy,

    output logic                     frag_start,
    output logic [`FB_X_BITS-1:0]    frag_x,
    output logic [`FB_Y_BITS-1:0]    frag_y,
    output fb_pkg::depth_t           frag_depth,
    output fb_pkg::color_t           frag_color,
    input  logic                     frag_done,

    output logic                     commit_start,
    input  logic                     scan_busy
);
    import fb_pkg::*;

    decoder_state_t state;
    cmd_op_t        op;
    logic           beat;

    // Words are taken only while no long operation runs
    assign cmd_tready = (state == DEC_IDLE) || (state == DEC_FRAG_COLOR);
    assign beat = cmd_tvalid && cmd_tready;
    assign op = cmd_op_t'(cmd_tdata[`FB_OP_MSB:`FB_OP_LSB]);

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state        <= DEC_IDLE;
            scissor      <= '0;
            memset_start <= 1'b0;
            frag_start   <= 1'b0;
            commit_start <= 1'b0;
        end
        else
        begin
            memset_start <= 1'b0;
            frag_start   <= 1'b0;
            commit_start <= 1'b0;
            case (state)
                DEC_IDLE:
                begin
                    if (beat)
                    begin
                        case (op)
                            OP_SET_SCISSOR_START:
                            begin
                                scissor.enable  <= cmd_tdata[8];
                                scissor.start_y <= cmd_tdata[7:4];
                                scissor.start_x <= cmd_tdata[3:0];
                            end
                            OP_SET_SCISSOR_END:
                            begin
                                scissor.end_y <= cmd_tdata[7:4];
                                scissor.end_x <= cmd_tdata[3:0];
                            end
                            OP_FRAGMENT:
                                state <= DEC_FRAG_COLOR;
                            OP_MEMSET:
                            begin
                                memset_start <= 1'b1;
                                state        <= DEC_MEMSET_WAIT;
                            end
                            OP_COMMIT:
                            begin
                                commit_start <= 1'b1;
                                state        <= DEC_COMMIT_WAIT;
                            end
                            default:
                                state <= DEC_IDLE;
                        endcase
                    end
                end
                DEC_FRAG_COLOR:
                begin
                    if (beat)
                    begin
                        frag_start <= 1'b1;
                        state      <= DEC_FRAG_WAIT;
                    end
                end
                DEC_FRAG_WAIT:
                    if (frag_done)
                        state <= DEC_IDLE;
                // Busy rises one cycle after the start pulse
                DEC_MEMSET_WAIT:
                    if (!memset_start && !memset_busy)
                        state <= DEC_IDLE;
                DEC_COMMIT_WAIT:
                    if (!commit_start && !scan_busy)
                        state <= DEC_IDLE;
                default:
                    state <= DEC_IDLE;
            endcase
        end
    end

    // Clear values and fragment payload
    always_ff @(posedge aclk)
    begin
        if (beat && state == DEC_IDLE)
        begin
            case (op)
                OP_SET_CLEAR_COLOR:
                    clear_color <= cmd_tdata[`FB_COLOR_BITS-1:0];
                OP_SET_CLEAR_DEPTH:
                    clear_depth <= cmd_tdata[`FB_DEPTH_BITS-1:0];
                OP_FRAGMENT:
                begin
                    frag_x     <= cmd_tdata[27:24];
                    frag_y     <= cmd_tdata[23:20];
                    frag_depth <= cmd_tdata[`FB_DEPTH_BITS-1:0];
                end
                default:
                    clear_depth <= clear_depth;
            endcase
        end
        // Second word of a fragment carries its color
        if (beat && state == DEC_FRAG_COLOR)
            frag_color <= cmd_tdata[`FB_COLOR_BITS-1:0];
    end

endmodule

/* logic/tile_buffer.sv */
// Tile memory with scissored fragment writes, a memset walker and a scan read port
`timescale 1ns/100ps
`include "fb_params.svh"

module tile_buffer #(
    parameter int DATA_BITS = 18
) (
    input  logic                      aclk,
    input  logic                      reset,

    input  fb_pkg::scissor_t          scissor,
    input  logic [DATA_BITS-1:0]      clear_value,
    input  logic                      memset_start,
    output logic                      memset_busy,

    fb_port_if.owner                  frag,

    input  logic [`FB_ADDR_BITS-1:0]  scan_addr,
    output logic [DATA_BITS-1:0]      scan_data
);
    import fb_pkg::*;

    logic [DATA_BITS-1:0]      mem [`FB_PIXELS];
    logic [`FB_ADDR_BITS-1:0]  walk_addr;

    // An end of 0 extends to 16 through the carry bit
    function automatic logic in_scissor(
        input scissor_t              s,
        input logic [`FB_X_BITS-1:0] x,
        input logic [`FB_Y_BITS-1:0] y
    );
        logic [`FB_X_BITS:0] end_x;
        logic [`FB_Y_BITS:0] end_y;
        end_x = {s.end_x == '0, s.end_x};
        end_y = {s.end_y == '0, s.end_y};
        return !s.enable || (x >= s.start_x && {1'b0, x} < end_x &&
                             y >= s.start_y && {1'b0, y} < end_y);
    endfunction

    // Walker visits every address once with x fastest
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            memset_busy <= 1'b0;
            walk_addr   <= '0;
        end
        else if (memset_start)
        begin
            memset_busy <= 1'b1;
            walk_addr   <= '0;
        end
        else if (memset_busy)
        begin
            walk_addr <= walk_addr + 1'b1;
            if (walk_addr == `FB_ADDR_BITS'(`FB_PIXELS - 1))
                memset_busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (memset_busy)
        begin
            if (in_scissor(scissor, walk_addr[`FB_X_BITS-1:0],
                           walk_addr[`FB_ADDR_BITS-1:`FB_X_BITS]))
                mem[walk_addr] <= clear_value;
        end
        else if (frag.wr_en && in_scissor(scissor, frag.x, frag.y))
        begin
            mem[frag.addr] <= frag.wdata;
        end

        if (frag.rd_en)
            frag.rdata <= mem[frag.addr];

        // Scan port reads every cycle
        scan_data <= mem[scan_addr];
    end

endmodule

/* logic/fragment_unit.sv */
// Depth tested fragment write over the color and depth buffers
`timescale 1ns/100ps
`include "fb_params.svh"

module fragment_unit (
    input  logic                   aclk,
    input  logic                   reset,

    input  logic                   frag_start,
    input  logic [`FB_X_BITS-1:0]  frag_x,
    input  logic [`FB_Y_BITS-1:0]  frag_y,
    input  fb_pkg::depth_t         frag_depth,
    input  fb_pkg::color_t         frag_color,
    output logic                   frag_done,

    fb_port_if.user                color_port,
    fb_port_if.user                depth_port
);
    import fb_pkg::*;

    logic [`FB_X_BITS-1:0]  x_q;
    logic [`FB_Y_BITS-1:0]  y_q;
    depth_t                 depth_q;
    color_t                 color_q;
    logic [`FB_X_BITS-1:0]  cur_x;
    logic [`FB_Y_BITS-1:0]  cur_y;
    logic                   cmp_phase;
    logic                   wr_phase;
    logic                   pass;

    // Read is issued in the start cycle and later cycles use the latched position
    assign cur_x = frag_start ? frag_x : x_q;
    assign cur_y = frag_start ? frag_y : y_q;

    assign color_port.rd_en = frag_start;
    assign color_port.addr  = {cur_y, cur_x};
    assign color_port.x     = cur_x;
    assign color_port.y     = cur_y;
    assign color_port.wr_en = wr_phase && pass;
    assign color_port.wdata = color_q;

    assign depth_port.rd_en = frag_start;
    assign depth_port.addr  = {cur_y, cur_x};
    assign depth_port.x     = cur_x;
    assign depth_port.y     = cur_y;
    assign depth_port.wr_en = wr_phase && pass;
    assign depth_port.wdata = depth_q;

    assign frag_done = wr_phase;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            cmp_phase <= 1'b0;
            wr_phase  <= 1'b0;
            pass      <= 1'b0;
        end
        else
        begin
            cmp_phase <= frag_start;
            wr_phase  <= cmp_phase;
            // Strictly nearer fragments win and equal depth keeps the old pixel
            if (cmp_phase)
                pass <= depth_q < depth_port.rdata;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (frag_start)
        begin
            x_q     <= frag_x;
            y_q     <= frag_y;
            depth_q <= frag_depth;
            color_q <= frag_color;
        end
    end

endmodule

/* logic/frame_scanout.sv */
// Color buffer scanout to an RGB565 stream with back-pressure
`timescale 1ns/100ps
`include "fb_params.svh"

module frame_scanout (
    input  logic                       aclk,
    input  logic                       reset,

    input  logic                       commit_start,
    output logic                       scan_busy,

    output logic [`FB_ADDR_BITS-1:0]   scan_addr,
    input  fb_pkg::color_t             scan_data,

    output logic                       tvalid,
    input  logic                       tready,
    output logic                       tlast,
    output logic [`FB_STREAM_BITS-1:0] tdata
);
    import fb_pkg::*;

    localparam int SUB = `FB_SUB_PIXEL_BITS;

    scan_state_t               state;
    logic [`FB_ADDR_BITS-1:0]  addr_q;
    logic                      data_ok;
    logic                      all_loaded;
    logic                      load;
    logic                      last_addr;
    logic [SUB-1:0]            red;
    logic [SUB-1:0]            green;
    logic [SUB-1:0]            blue;

    assign scan_busy = (state == SCAN_STREAM);
    assign last_addr = (addr_q == `FB_ADDR_BITS'(`FB_PIXELS - 1));
    // Output register takes a pixel when empty or draining this cycle
    assign load = scan_busy && data_ok && !all_loaded && (!tvalid || tready);
    // Address runs one ahead on a load so the next pixel is ready right after
    assign scan_addr = load ? addr_q + 1'b1 : addr_q;

    assign red   = scan_data[3*SUB-1 -: SUB];
    assign green = scan_data[2*SUB-1 -: SUB];
    assign blue  = scan_data[SUB-1:0];

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state      <= SCAN_IDLE;
            addr_q     <= '0;
            data_ok    <= 1'b0;
            all_loaded <= 1'b0;
            tvalid     <= 1'b0;
            tlast      <= 1'b0;
        end
        else
        begin
            case (state)
                SCAN_IDLE:
                begin
                    if (commit_start)
                    begin
                        state      <= SCAN_STREAM;
                        addr_q     <= '0;
                        data_ok    <= 1'b0;
                        all_loaded <= 1'b0;
                    end
                end
                SCAN_STREAM:
                begin
                    data_ok <= 1'b1;
                    if (load)
                    begin
                        addr_q <= addr_q + 1'b1;
                        tvalid <= 1'b1;
                        tlast  <= last_addr;
                        if (last_addr)
                            all_loaded <= 1'b1;
                    end
                    else if (tready)
                    begin
                        tvalid <= 1'b0;
                        tlast  <= 1'b0;
                    end
                    if (tvalid && tready && tlast)
                        state <= SCAN_IDLE;
                end
                default:
                    state <= SCAN_IDLE;
            endcase
        end
    end

    // RGB666 to RGB565 where green keeps all six bits
    always_ff @(posedge aclk)
    begin
        if (load)
            tdata <= {red[SUB-1:1], green, blue[SUB-1:1]};
    end

endmodule

/* logic/tile_framebuffer.sv */
// Tile framebuffer top level with a command stream in and an RGB565 framebuffer stream out
`timescale 1ns/100ps
`include "fb_params.svh"

module tile_framebuffer (
    input  logic                        aclk,
    input  logic                        reset,

    input  logic                        s_cmd_axis_tvalid,
    output logic                        s_cmd_axis_tready,
    input  logic                        s_cmd_axis_tlast,
    input  logic [`FB_CMD_BITS-1:0]     s_cmd_axis_tdata,

    output logic                        m_framebuffer_axis_tvalid,
    input  logic                        m_framebuffer_axis_tready,
    output logic                        m_framebuffer_axis_tlast,
    output logic [`FB_STREAM_BITS-1:0]  m_framebuffer_axis_tdata
);
    import fb_pkg::*;

    // Command words carry no packet structure and their tlast is ignored
    scissor_t                  scissor;
    color_t                    clear_color;
    depth_t                    clear_depth;
    logic                      memset_start;
    logic                      memset_busy;
    logic                      frag_start;
    logic [`FB_X_BITS-1:0]     frag_x;
    logic [`FB_Y_BITS-1:0]     frag_y;
    depth_t                    frag_depth;
    color_t                    frag_color;
    logic                      frag_done;
    logic                      commit_start;
    logic                      scan_busy;
    logic [`FB_ADDR_BITS-1:0]  scan_addr;
    color_t                    scan_data;

    fb_port_if #(.DATA_BITS(`FB_COLOR_BITS)) color_port ();
    fb_port_if #(.DATA_BITS(`FB_DEPTH_BITS)) depth_port ();

    cmd_decoder i_cmd_decoder (
        .aclk         (aclk),
        .reset        (reset),
        .cmd_tvalid   (s_cmd_axis_tvalid),
        .cmd_tready   (s_cmd_axis_tready),
        .cmd_tdata    (s_cmd_axis_tdata),
        .scissor      (scissor),
        .clear_color  (clear_color),
        .clear_depth  (clear_depth),
        .memset_start (memset_start),
        .memset_busy  (memset_busy),
        .frag_start   (frag_start),
        .frag_x       (frag_x),
        .frag_y       (frag_y),
        .frag_depth   (frag_depth),
        .frag_color   (frag_color),
        .frag_done    (frag_done),
        .commit_start (commit_start),
        .scan_busy    (scan_busy)
    );

    tile_buffer #(.DATA_BITS(`FB_COLOR_BITS)) color_buffer (
        .aclk         (aclk),
        .reset        (reset),
        .scissor      (scissor),
        .clear_value  (clear_color),
        .memset_start (memset_start),
        .memset_busy  (memset_busy),
        .frag         (color_port.owner),
        .scan_addr    (scan_addr),
        .scan_data    (scan_data)
    );

    // Both walkers start together so the color busy covers the pair
    tile_buffer #(.DATA_BITS(`FB_DEPTH_BITS)) depth_buffer (
        .aclk         (aclk),
        .reset        (reset),
        .scissor      (scissor),
        .clear_value  (clear_depth),
        .memset_start (memset_start),
        .memset_busy  (),
        .frag         (depth_port.owner),
        .scan_addr    ('0),
        .scan_data    ()
    );

    fragment_unit i_fragment_unit (
        .aclk         (aclk),
        .reset        (reset),
        .frag_start   (frag_start),
        .frag_x       (frag_x),
        .frag_y       (frag_y),
        .frag_depth   (frag_depth),
        .frag_color   (frag_color),
        .frag_done    (frag_done),
        .color_port   (color_port.user),
        .depth_port   (depth_port.user)
    );

    frame_scanout i_frame_scanout (
        .aclk         (aclk),
        .reset        (reset),
        .commit_start (commit_start),
        .scan_busy    (scan_busy),
        .scan_addr    (scan_addr),
        .scan_data    (scan_data),
        .tvalid       (m_framebuffer_axis_tvalid),
        .tready       (m_framebuffer_axis_tready),
        .tlast        (m_framebuffer_axis_tlast),
        .tdata        (m_framebuffer_axis_tdata)
    );

endmodule

/* bench/tile_framebuffer_sva.sv */
// Handshake assertions on the command and framebuffer streams of the tile framebuffer
`timescale 1ns/100ps
`include "fb_params.svh"

module tile_framebuffer_sva (
    input  logic                        aclk,
    input  logic                        reset,
    input  logic                        s_cmd_axis_tready,
    input  logic                        m_framebuffer_axis_tvalid,
    input  logic                        m_framebuffer_axis_tready,
    input  logic                        m_framebuffer_axis_tlast,
    input  logic [`FB_STREAM_BITS-1:0]  m_framebuffer_axis_tdata
);

    // A stalled beat keeps its payload until taken
    property stalled_beat_holds;
        @(posedge aclk) disable iff (reset)
        m_framebuffer_axis_tvalid && !m_framebuffer_axis_tready |=>
            m_framebuffer_axis_tvalid && $stable(m_framebuffer_axis_tdata) &&
            $stable(m_framebuffer_axis_tlast);
    endproperty

    a_stalled_beat_holds: assert property (stalled_beat_holds)
        else $error("framebuffer beat changed or vanished while stalled");

    a_tlast_with_tvalid: assert property (
        @(posedge aclk) disable iff (reset)
        m_framebuffer_axis_tlast |-> m_framebuffer_axis_tvalid)
        else $error("framebuffer tlast high without tvalid");

    // No command is taken while a commit is streaming
    a_cmd_blocked_in_commit: assert property (
        @(posedge aclk) disable iff (reset)
        m_framebuffer_axis_tvalid |-> !s_cmd_axis_tready)
        else $error("command stream ready during framebuffer output");

endmodule

bind tile_framebuffer tile_framebuffer_sva i_tile_framebuffer_sva (
    .aclk                      (aclk),
    .reset                     (reset),
    .s_cmd_axis_tready         (s_cmd_axis_tready),
    .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
    .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
    .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
    .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata)
);

/* bench/tile_framebuffer_tb.sv */
// Testbench for the tile framebuffer with a command table and a behavioral buffer model
`timescale 1ns/100ps
`include "fb_params.svh"

module tile_framebuffer_tb;
    import fb_pkg::*;

    localparam int TIMEOUT = 1000;
    localparam logic [31:0] SEED = 32'h51efbef1;

    typedef enum logic [1:0] {
        STEP_CMD,
        STEP_COMMIT,
        STEP_PIXEL
    } step_kind_t;

    // A pixel check keeps its expected RGB565 value in word[15:0]
    typedef struct packed {
        step_kind_t   kind;
        logic [3:0]   x;
        logic [3:0]   y;
        logic [31:0]  word;
    } step_t;

    logic                         aclk;
    logic                         reset;
    logic                         s_cmd_axis_tvalid;
    logic                         s_cmd_axis_tready;
    logic                         s_cmd_axis_tlast;
    logic [`FB_CMD_BITS-1:0]      s_cmd_axis_tdata;
    logic                         m_framebuffer_axis_tvalid;
    logic                         m_framebuffer_axis_tready;
    logic                         m_framebuffer_axis_tlast;
    logic [`FB_STREAM_BITS-1:0]   m_framebuffer_axis_tdata;

    step_t                        steps[$];
    int                           errors;
    int                           timeouts;
    logic                         timed_out;

    // Behavioral model of both buffers and the configuration
    logic [`FB_COLOR_BITS-1:0]    model_color [`FB_PIXELS];
    logic [`FB_DEPTH_BITS-1:0]    model_depth [`FB_PIXELS];
    logic [`FB_STREAM_BITS-1:0]   got_frame [`FB_PIXELS];
    logic [`FB_COLOR_BITS-1:0]    set_color;
    logic [`FB_DEPTH_BITS-1:0]    set_depth;
    logic                         sc_en;
    logic [3:0]                   sc_sx;
    logic [3:0]                   sc_sy;
    logic [3:0]                   sc_ex;
    logic [3:0]                   sc_ey;
    logic                         frag_pending;
    logic [3:0]                   pend_x;
    logic [3:0]                   pend_y;
    logic [`FB_DEPTH_BITS-1:0]    pend_depth;

    tile_framebuffer i_tile_framebuffer (
        .aclk                      (aclk),
        .reset                     (reset),
        .s_cmd_axis_tvalid         (s_cmd_axis_tvalid),
        .s_cmd_axis_tready         (s_cmd_axis_tready),
        .s_cmd_axis_tlast          (s_cmd_axis_tlast),
        .s_cmd_axis_tdata          (s_cmd_axis_tdata),
        .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
        .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
        .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata)
    );

    initial
    begin
        aclk = 1'b0;
        forever
            #50 aclk = ~aclk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("error %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    function automatic logic [15:0] to_rgb565(input logic [17:0] c);
        return {c[17:13], c[11:6], c[5:1]};
    endfunction

    // End is exclusive and 0 stands for 16
    function automatic logic window_allows(input int x, input int y);
        int ex;
        int ey;
        ex = (sc_ex == 4'd0) ? 16 : int'(sc_ex);
        ey = (sc_ey == 4'd0) ? 16 : int'(sc_ey);
        return !sc_en || (x >= sc_sx && x < ex && y >= sc_sy && y < ey);
    endfunction

    task automatic apply_to_model(input logic [31:0] w);
        int i;
        if (frag_pending)
        begin
            frag_pending = 1'b0;
            i = pend_y * 16 + pend_x;
            if (window_allows(pend_x, pend_y) && pend_depth < model_depth[i])
            begin
                model_color[i] = w[17:0];
                model_depth[i] = pend_depth;
            end
        end
        else
        begin
            case (cmd_op_t'(w[31:28]))
                OP_SET_CLEAR_COLOR:
                    set_color = w[17:0];
                OP_SET_CLEAR_DEPTH:
                    set_depth = w[15:0];
                OP_SET_SCISSOR_START:
                begin
                    sc_en = w[8];
                    sc_sy = w[7:4];
                    sc_sx = w[3:0];
                end
                OP_SET_SCISSOR_END:
                begin
                    sc_ey = w[7:4];
                    sc_ex = w[3:0];
                end
                OP_FRAGMENT:
                begin
                    frag_pending = 1'b1;
                    pend_x     = w[27:24];
                    pend_y     = w[23:20];
                    pend_depth = w[15:0];
                end
                OP_MEMSET:
                begin
                    for (i = 0; i < `FB_PIXELS; i++)
                    begin
                        if (window_allows(i % 16, i / 16))
                        begin
                            model_color[i] = set_color;
                            model_depth[i] = set_depth;
                        end
                    end
                end
                default:
                    i = 0;
            endcase
        end
    endtask

    task automatic wait_cmd_ready(input string what);
        int waited;
        waited = 0;
        while (!s_cmd_axis_tready && waited < TIMEOUT)
        begin
            @(negedge aclk);
            waited++;
        end
        if (!s_cmd_axis_tready)
        begin
            $display("timeout: command stream stayed blocked %s", what);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic send_word(input logic [31:0] w);
        s_cmd_axis_tvalid = 1'b1;
        s_cmd_axis_tdata  = w;
        wait_cmd_ready($sformatf("before word %h", w));
        if (!timed_out)
        begin
            @(negedge aclk);
            apply_to_model(w);
        end
        s_cmd_axis_tvalid = 1'b0;
    endtask

    task automatic capture_frame(input logic random_ready);
        int beat;
        int waited;
        beat = 0;
        waited = 0;
        while (beat < `FB_PIXELS && waited < TIMEOUT)
        begin
            m_framebuffer_axis_tready = random_ready ? (($urandom % 2) == 1) : 1'b1;
            check_value("s_cmd_axis_tready", s_cmd_axis_tready, 0);
            if (m_framebuffer_axis_tvalid && m_framebuffer_axis_tready)
            begin
                got_frame[beat] = m_framebuffer_axis_tdata;
                check_value("m_framebuffer_axis_tlast", m_framebuffer_axis_tlast,
                            beat == `FB_PIXELS - 1);
                beat++;
                waited = 0;
            end
            else
                waited++;
            @(negedge aclk);
        end
        m_framebuffer_axis_tready = 1'b1;
        if (beat < `FB_PIXELS)
        begin
            $display("timeout: frame stopped after %0d of 256 beats", beat);
            timeouts++;
            timed_out = 1'b1;
        end
        else
        begin
            // A 257th beat would still be valid here
            check_value("m_framebuffer_axis_tvalid", m_framebuffer_axis_tvalid, 0);
            wait_cmd_ready("after the commit");
            for (int i = 0; i < `FB_PIXELS; i++)
                check_value($sformatf("m_framebuffer_axis_tdata beat %0d", i),
                            got_frame[i], to_rgb565(model_color[i]));
        end
    endtask

    task automatic add_step(input step_kind_t kind, input int x, input int y,
                            input logic [31:0] word);
        steps.push_back('{kind, 4'(x), 4'(y), word});
    endtask

    task automatic build_table();
        // Full clear with the scissor off
        add_step(STEP_CMD, 0, 0, {OP_SET_CLEAR_COLOR, 28'h002A57F});
        add_step(STEP_CMD, 0, 0, {OP_SET_CLEAR_DEPTH, 28'h000FFFF});
        add_step(STEP_CMD, 0, 0, {OP_SET_SCISSOR_START, 28'h0});
        add_step(STEP_CMD, 0, 0, {OP_MEMSET, 28'h0});
        add_step(STEP_COMMIT, 0, 0, 32'h0);
        add_step(STEP_PIXEL, 0, 0, 32'hAABF);
        add_step(STEP_PIXEL, 15, 15, 32'hAABF);
        // Depth test at (3,2) with a nearer, a farther and an equal fragment
        add_step(STEP_CMD, 0, 0, {OP_FRAGMENT, 28'h3208000});
        add_step(STEP_CMD, 0, 0, 32'h0003F000);
        add_step(STEP_CMD, 0, 0, {OP_FRAGMENT, 28'h3209000});
        add_step(STEP_CMD, 0, 0, 32'h00000FC0);
        add_step(STEP_CMD, 0, 0, {OP_FRAGMENT, 28'h3208000});
        add_step(STEP_CMD, 0, 0, 32'h0000003F);
        add_step(STEP_COMMIT, 0, 0, 32'h0);
        add_step(STEP_PIXEL, 3, 2, 32'hF800);
        add_step(STEP_CMD, 0, 0, {OP_FRAGMENT, 28'h3207FFF});
        add_step(STEP_CMD, 0, 0, 32'h00015555);
        add_step(STEP_CMD, 0, 0, 32'hF0000000);
        // Window over x 2..5 and y 4..7
        add_step(STEP_CMD, 0, 0, {OP_SET_CLEAR_COLOR, 28'h0001FC2});
        add_step(STEP_CMD, 0, 0, {OP_SET_SCISSOR_START, 28'h0000142});
        add_step(STEP_CMD, 0, 0, {OP_SET_SCISSOR_END, 28'h0000086});
        add_step(STEP_CMD, 0, 0, {OP_MEMSET, 28'h0});
        add_step(STEP_CMD, 0, 0, {OP_FRAGMENT, 28'h5701000});
        add_step(STEP_CMD, 0, 0, 32'h0003F03F);
        add_step(STEP_CMD, 0, 0, {OP_FRAGMENT, 28'h6701000});
        add_step(STEP_CMD, 0, 0, 32'h0003F03F);
        add_step(STEP_CMD, 0, 0, {OP_FRAGMENT, 28'h5801000});
        add_step(STEP_CMD, 0, 0, 32'h0003F03F);
        add_step(STEP_COMMIT, 0, 0, 32'h1);
        add_step(STEP_PIXEL, 2, 4, 32'h07E1);
        add_step(STEP_PIXEL, 5, 7, 32'hF81F);
        add_step(STEP_PIXEL, 6, 7, 32'hAABF);
        add_step(STEP_PIXEL, 5, 8, 32'hAABF);
        add_step(STEP_PIXEL, 1, 4, 32'hAABF);
        add_step(STEP_PIXEL, 3, 2, 32'h52AA);
    endtask

    task automatic run_step(input step_t s);
        case (s.kind)
            STEP_CMD:
                send_word(s.word);
            STEP_COMMIT:
            begin
                send_word({OP_COMMIT, 28'h0});
                if (!timed_out)
                    capture_frame(s.word[0]);
            end
            default:
                check_value($sformatf("m_framebuffer_axis_tdata at (%0d,%0d)", s.x, s.y),
                            got_frame[s.y * 16 + s.x], s.word[15:0]);
        endcase
    endtask

    initial
    begin
        void'($urandom(SEED));
        errors = 0;
        timeouts = 0;
        timed_out = 1'b0;
        frag_pending = 1'b0;
        sc_en = 1'b0;
        sc_sx = '0;
        sc_sy = '0;
        sc_ex = '0;
        sc_ey = '0;
        reset = 1'b1;
        s_cmd_axis_tvalid = 1'b0;
        s_cmd_axis_tlast = 1'b0;
        s_cmd_axis_tdata = '0;
        m_framebuffer_axis_tready = 1'b1;
        build_table();
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        check_value("s_cmd_axis_tready", s_cmd_axis_tready, 1);
        check_value("m_framebuffer_axis_tvalid", m_framebuffer_axis_tvalid, 0);
        for (int i = 0; i < steps.size() && !timed_out; i++)
            run_step(steps[i]);
        $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/fb_pkg.sv
logic/fb_port_if.sv
logic/cmd_decoder.sv
logic/tile_buffer.sv
logic/fragment_unit.sv
logic/frame_scanout.sv
logic/tile_framebuffer.sv
bench/tile_framebuffer_sva.sv
bench/tile_framebuffer_tb.sv
